//--- filelist.f
+incdir+logic
logic/mipsPkg.sv
logic/stageIfs.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/resultStage.sv
logic/mipsCore.sv
verif/mipsCoreTb.sv

//--- logic/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module decodeStage (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              instrValid,
    input  mipsPkg::word_t    instr,
    regReadIf.decode          rd,
    issueIf.decode            iss,
    input  logic              fwdValid,
    input  mipsPkg::regAddr_t fwdReg,
    input  mipsPkg::word_t    fwdValue
);
    import mipsPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    regAddr_t    rsField;
    regAddr_t    rtField;
    regAddr_t    rdField;
    shamt_t      shamtField;
    logic [15:0] imm;

    word_t       immSext;
    word_t       immZext;
    word_t       immExt;
    logic        isRType;
    logic        legal;
    logic        useImm;
    aluOp_t      aluOpNext;
    regAddr_t    destNext;
    word_t       srcA;
    word_t       srcB;

    // Instruction fields
    assign opcode     = instr[31:26];
    assign rsField    = instr[25:21];
    assign rtField    = instr[20:16];
    assign rdField    = instr[15:11];
    assign shamtField = instr[10:6];
    assign funct      = instr[5:0];
    assign imm        = instr[15:0];

    assign isRType = (opcode == `MIPS_OP_SPECIAL);
    assign immSext = {{16{imm[15]}}, imm};
    assign immZext = {16'h0000, imm};

    // ----------------------------------------------------------
    // Legality check and ALU operation select
    // ----------------------------------------------------------
    always_comb begin
        legal     = 1'b1;
        useImm    = !isRType;
        aluOpNext = `MIPS_ALU_ADD;
        immExt    = immSext;
        if (isRType) begin
            case (funct)
                `MIPS_FN_ADDU: aluOpNext = `MIPS_ALU_ADD;
                `MIPS_FN_SUBU: aluOpNext = `MIPS_ALU_SUB;
                `MIPS_FN_AND:  aluOpNext = `MIPS_ALU_AND;
                `MIPS_FN_OR:   aluOpNext = `MIPS_ALU_OR;
                `MIPS_FN_XOR:  aluOpNext = `MIPS_ALU_XOR;
                `MIPS_FN_NOR:  aluOpNext = `MIPS_ALU_NOR;
                `MIPS_FN_SLT:  aluOpNext = `MIPS_ALU_SLT;
                `MIPS_FN_SLTU: aluOpNext = `MIPS_ALU_SLTU;
                `MIPS_FN_SLL:  aluOpNext = `MIPS_ALU_SLL;
                `MIPS_FN_SRL:  aluOpNext = `MIPS_ALU_SRL;
                `MIPS_FN_SRA:  aluOpNext = `MIPS_ALU_SRA;
                default:       legal     = 1'b0;
            endcase
        end else begin
            case (opcode)
                `MIPS_OP_ADDIU: aluOpNext = `MIPS_ALU_ADD;
                `MIPS_OP_SLTI:  aluOpNext = `MIPS_ALU_SLT;
                // SLTIU compares unsigned against the sign extended immediate
                `MIPS_OP_SLTIU: aluOpNext = `MIPS_ALU_SLTU;
                `MIPS_OP_ANDI: begin
                    aluOpNext = `MIPS_ALU_AND;
                    immExt    = immZext;
                end
                `MIPS_OP_ORI: begin
                    aluOpNext = `MIPS_ALU_OR;
                    immExt    = immZext;
                end
                `MIPS_OP_XORI: begin
                    aluOpNext = `MIPS_ALU_XOR;
                    immExt    = immZext;
                end
                `MIPS_OP_LUI: begin
                    aluOpNext = `MIPS_ALU_PASSB;
                    immExt    = {imm, 16'h0000};
                end
                default: legal = 1'b0;
            endcase
        end
    end

    assign destNext = isRType ? rdField : rtField;

    // ----------------------------------------------------------
    // Source operands
    // ----------------------------------------------------------
    assign rd.addrA = rsField;
    assign rd.addrB = rtField;

    // Execute holds the newest value, register 0 is never forwarded
    function automatic word_t pickSource(input regAddr_t addr, input word_t fileData);
        word_t value;
        if (fwdValid && (fwdReg != '0) && (fwdReg == addr)) begin
            value = fwdValue;
        end else begin
            value = fileData;
        end
        return value;
    endfunction

    always_comb begin
        srcA = pickSource(rsField, rd.dataA);
        srcB = pickSource(rtField, rd.dataB);
    end

    // Decode/execute register
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            iss.valid    <= 1'b0;
            iss.aluOp    <= '0;
            iss.operandA <= '0;
            iss.operandB <= '0;
            iss.shamt    <= '0;
            iss.destReg  <= '0;
        end else begin
            iss.valid    <= instrValid && legal;
            iss.aluOp    <= aluOpNext;
            iss.operandA <= srcA;
            iss.operandB <= useImm ? immExt : srcB;
            iss.shamt    <= shamtField;
            iss.destReg  <= destNext;
        end
    end

    issueValidKnown: assert property (
        @(posedge CLK) disable iff (!rstN) !$isunknown(iss.valid)
    ) else $error("issue valid is unknown");

endmodule

`default_nettype wire

//--- logic/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module executeStage (
    input  logic              CLK,
    input  logic              rstN,
    issueIf.execute           iss,
    resultIf.execute          res,
    output logic              fwdValid,
    output mipsPkg::regAddr_t fwdReg,
    output mipsPkg::word_t    fwdValue
);
    import mipsPkg::*;

    word_t aluOut;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    always_comb begin
        case (iss.aluOp)
            `MIPS_ALU_ADD:   aluOut = iss.operandA + iss.operandB;
            `MIPS_ALU_SUB:   aluOut = iss.operandA - iss.operandB;
            `MIPS_ALU_AND:   aluOut = iss.operandA & iss.operandB;
            `MIPS_ALU_OR:    aluOut = iss.operandA | iss.operandB;
            `MIPS_ALU_XOR:   aluOut = iss.operandA ^ iss.operandB;
            `MIPS_ALU_NOR:   aluOut = ~(iss.operandA | iss.operandB);
            `MIPS_ALU_SLT: begin
                aluOut = word_t'($signed(iss.operandA) < $signed(iss.operandB));
            end
            `MIPS_ALU_SLTU:  aluOut = word_t'(iss.operandA < iss.operandB);
            // Shifts act on operand B by the instruction shamt
            `MIPS_ALU_SLL:   aluOut = iss.operandB << iss.shamt;
            `MIPS_ALU_SRL:   aluOut = iss.operandB >> iss.shamt;
            `MIPS_ALU_SRA:   aluOut = word_t'($signed(iss.operandB) >>> iss.shamt);
            `MIPS_ALU_PASSB: aluOut = iss.operandB;
            default:         aluOut = '0;
        endcase
    end

    // Bypass to decode for the item now in execute
    assign fwdValid = iss.valid;
    assign fwdReg   = iss.destReg;
    assign fwdValue = aluOut;

    // Execute/result register
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            res.valid   <= 1'b0;
            res.destReg <= '0;
            res.value   <= '0;
        end else begin
            res.valid   <= iss.valid;
            res.destReg <= iss.destReg;
            res.value   <= aluOut;
        end
    end

    resultKnown: assert property (
        @(posedge CLK) disable iff (!rstN)
        res.valid |-> !$isunknown({res.destReg, res.value})
    ) else $error("valid result carries unknown bits");

endmodule

`default_nettype wire

//--- logic/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              instrValid,
    input  mipsPkg::word_t    instr,
    output logic              retireValid,
    output mipsPkg::regAddr_t retireReg,
    output mipsPkg::word_t    retireData
);
    import mipsPkg::*;

    // Stage to stage buses
    issueIf   issueBus ();
    resultIf  resultBus ();
    regReadIf regBus ();

    // Bypass from execute back to decode
    logic     fwdValid;
    regAddr_t fwdReg;
    word_t    fwdValue;

    decodeStage decode0 (
        .CLK        (CLK),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rd         (regBus.decode),
        .iss        (issueBus.decode),
        .fwdValid   (fwdValid),
        .fwdReg     (fwdReg),
        .fwdValue   (fwdValue)
    );

    executeStage execute0 (
        .CLK      (CLK),
        .rstN     (rstN),
        .iss      (issueBus.execute),
        .res      (resultBus.execute),
        .fwdValid (fwdValid),
        .fwdReg   (fwdReg),
        .fwdValue (fwdValue)
    );

    resultStage result0 (
        .CLK         (CLK),
        .rstN        (rstN),
        .res         (resultBus.result),
        .rd          (regBus.result),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

endmodule

`default_nettype wire

//--- logic/mipsPkg.sv
`default_nettype none

`include "mips_defines.svh"

package mipsPkg;

    // ----------------------------------------------------------
    // Vector types shared by the pipeline stages
    // ----------------------------------------------------------

    // Data word, also used for the raw instruction word
    typedef logic [`MIPS_XLEN-1:0] word_t;

    // Architectural register number
    typedef logic [`MIPS_REG_BITS-1:0] regAddr_t;

    // Shift amount taken from the instruction
    typedef logic [4:0] shamt_t;

    // Operation select for the execute ALU
    typedef logic [`MIPS_ALU_OP_BITS-1:0] aluOp_t;

endpackage

`default_nettype wire

//--- logic/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and register file sizes
`define MIPS_XLEN          32
`define MIPS_NUM_REGS      32
`define MIPS_REG_BITS      5
`define MIPS_ALU_OP_BITS   4

// Primary opcodes
`define MIPS_OP_SPECIAL    6'h00
`define MIPS_OP_ADDIU      6'h09
`define MIPS_OP_SLTI       6'h0A
`define MIPS_OP_SLTIU      6'h0B
`define MIPS_OP_ANDI       6'h0C
`define MIPS_OP_ORI        6'h0D
`define MIPS_OP_XORI       6'h0E
`define MIPS_OP_LUI        6'h0F

// Function field of SPECIAL
`define MIPS_FN_SLL        6'h00
`define MIPS_FN_SRL        6'h02
`define MIPS_FN_SRA        6'h03
`define MIPS_FN_ADDU       6'h21
`define MIPS_FN_SUBU       6'h23
`define MIPS_FN_AND        6'h24
`define MIPS_FN_OR         6'h25
`define MIPS_FN_XOR        6'h26
`define MIPS_FN_NOR        6'h27
`define MIPS_FN_SLT        6'h2A
`define MIPS_FN_SLTU       6'h2B

// ALU operation codes
`define MIPS_ALU_ADD       4'd0
`define MIPS_ALU_SUB       4'd1
`define MIPS_ALU_AND       4'd2
`define MIPS_ALU_OR        4'd3
`define MIPS_ALU_XOR       4'd4
`define MIPS_ALU_NOR       4'd5
`define MIPS_ALU_SLT       4'd6
`define MIPS_ALU_SLTU      4'd7
`define MIPS_ALU_SLL       4'd8
`define MIPS_ALU_SRL       4'd9
`define MIPS_ALU_SRA       4'd10
`define MIPS_ALU_PASSB     4'd11

`endif

//--- logic/resultStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module resultStage (
    input  logic               CLK,
    input  logic               rstN,
    resultIf.result            res,
    regReadIf.result           rd,
    output logic               retireValid,
    output mipsPkg::regAddr_t  retireReg,
    output mipsPkg::word_t     retireData
);
    import mipsPkg::*;

    // Register 0 has no storage
    word_t regs [1:`MIPS_NUM_REGS-1];

    // ----------------------------------------------------------
    // Register file write
    // ----------------------------------------------------------
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (res.valid && (res.destReg != '0)) begin
            regs[res.destReg] <= res.value;
        end
    end

    // Read with write-through of the value being written this cycle
    function automatic word_t readReg(input regAddr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (res.valid && (res.destReg == addr)) begin
            value = res.value;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rd.dataA = readReg(rd.addrA);
        rd.dataB = readReg(rd.addrB);
    end

    // ----------------------------------------------------------
    // Retire port
    // ----------------------------------------------------------
    // A write to register 0 still retires with the computed value
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            retireValid <= 1'b0;
            retireReg   <= '0;
            retireData  <= '0;
        end else begin
            retireValid <= res.valid;
            retireReg   <= res.destReg;
            retireData  <= res.value;
        end
    end

endmodule

`default_nettype wire

//--- logic/stageIfs.sv
`timescale 1ns/100ps
`default_nettype none

// ----------------------------------------------------------
// Decode to execute
// ----------------------------------------------------------
interface issueIf;
    import mipsPkg::*;

    logic     valid;
    aluOp_t   aluOp;
    word_t    operandA;
    word_t    operandB;
    shamt_t   shamt;
    regAddr_t destReg;

    modport decode (
        output valid,
        output aluOp,
        output operandA,
        output operandB,
        output shamt,
        output destReg
    );

    modport execute (
        input valid,
        input aluOp,
        input operandA,
        input operandB,
        input shamt,
        input destReg
    );
endinterface

// ----------------------------------------------------------
// Execute to result
// ----------------------------------------------------------
interface resultIf;
    import mipsPkg::*;

    logic     valid;
    regAddr_t destReg;
    word_t    value;

    modport execute (output valid, output destReg, output value);
    modport result (input valid, input destReg, input value);
endinterface

// ----------------------------------------------------------
// Register file read ports, data returns in the same cycle
// ----------------------------------------------------------
interface regReadIf;
    import mipsPkg::*;

    regAddr_t addrA;
    regAddr_t addrB;
    word_t    dataA;
    word_t    dataB;

    modport decode (output addrA, output addrB, input dataA, input dataB);
    modport result (input addrA, input addrB, output dataA, output dataB);
endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module mipsCoreTb \
    -f filelist.f \
    -o mipsCoreSim

./obj_dir/mipsCoreSim 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- verif/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defines.svh"

module mipsCoreTb;
    import mipsPkg::*;

    localparam int ResetCycles = 10;
    localparam int IdleCycles  = 20;
    localparam int NumRType    = 400;
    localparam int NumIType    = 300;
    localparam int NumChain    = 300;
    localparam int NumMixed    = 300;
    // Each mixed slot may add one gap cycle
    localparam int StimCycles  = ResetCycles + IdleCycles + NumRType + NumIType
                                 + NumChain + 2 * NumMixed + 10;
    localparam int CycleLimit  = 2 * StimCycles + 50;

    typedef struct packed {
        regAddr_t destReg;
        word_t    value;
        int       cycle;
    } retireExp_t;

    logic        CLK;
    logic        rstN;
    logic        instrValid;
    word_t       instr;
    logic        retireValid;
    regAddr_t    retireReg;
    word_t       retireData;

    logic [31:0] lfsrState = 32'h066a_a57f;
    int          cycleCount = 0;
    word_t       modelRegs [`MIPS_NUM_REGS];
    retireExp_t  expQ [$];
    retireExp_t  popped;

    mipsCore dut0 (
        .CLK         (CLK),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireData  (retireData)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout after %0d cycles with %0d retires still expected",
                     cycleCount, expQ.size());
            abortRun();
        end
    end

    // ----------------------------------------------------------
    // Random numbers and instruction generators
    // ----------------------------------------------------------
    // Galois LFSR stepped once per bit
    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], stepLfsr()};
        end
        return bits;
    endfunction

    function automatic regAddr_t randomReg();
        return regAddr_t'(takeBits(5));
    endfunction

    // Registers 1 to 4 only so neighbours depend on each other
    function automatic regAddr_t chainReg();
        return regAddr_t'(32'd1 + takeBits(2));
    endfunction

    function automatic logic isKeptFunct(input logic [5:0] fn);
        logic kept;
        case (fn)
            `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA, `MIPS_FN_ADDU, `MIPS_FN_SUBU,
            `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR, `MIPS_FN_SLT,
            `MIPS_FN_SLTU: kept = 1'b1;
            default:       kept = 1'b0;
        endcase
        return kept;
    endfunction

    function automatic word_t randomR(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd);
        logic [5:0] fn;
        fn = 6'(takeBits(6));
        while (!isKeptFunct(fn)) begin
            fn = 6'(takeBits(6));
        end
        return {`MIPS_OP_SPECIAL, rs, rt, rd, shamt_t'(takeBits(5)), fn};
    endfunction

    // Kept I-type opcodes are 6'h09 through 6'h0F
    function automatic word_t randomI(input regAddr_t rs, input regAddr_t rt, input logic negImm);
        logic [2:0]  sel;
        logic [15:0] imm;
        sel = 3'(takeBits(3));
        while (sel == 3'd0) begin
            sel = 3'(takeBits(3));
        end
        imm = 16'(takeBits(16));
        imm[15] = imm[15] | negImm;
        return {3'b001, sel, rs, rt, imm};
    endfunction

    function automatic word_t randomIllegal();
        logic [5:0] code;
        word_t      body;
        body = takeBits(32);
        if (takeBits(1) != '0) begin
            code = `MIPS_OP_SPECIAL;
            while (isKeptFunct(body[5:0])) begin
                body[5:0] = 6'(takeBits(6));
            end
        end else begin
            code = 6'(takeBits(6));
            while (code == `MIPS_OP_SPECIAL ||
                   (code >= `MIPS_OP_ADDIU && code <= `MIPS_OP_LUI)) begin
                code = 6'(takeBits(6));
            end
        end
        return {code, body[25:0]};
    endfunction

    // ----------------------------------------------------------
    // Reference model in program order
    // ----------------------------------------------------------
    task automatic executeModel(input word_t word);
        regAddr_t   rs;
        regAddr_t   rt;
        shamt_t     sh;
        word_t      a;
        word_t      b;
        word_t      immS;
        word_t      immZ;
        logic       legal;
        retireExp_t item;
        rs    = word[25:21];
        rt    = word[20:16];
        sh    = word[10:6];
        a     = modelRegs[rs];
        b     = modelRegs[rt];
        immS  = {{16{word[15]}}, word[15:0]};
        immZ  = {16'h0000, word[15:0]};
        legal = 1'b1;
        item.destReg = rt;
        item.value   = '0;
        // Retire shows three cycles after the instruction is driven
        item.cycle   = cycleCount + 3;
        if (word[31:26] == `MIPS_OP_SPECIAL) begin
            item.destReg = word[15:11];
            case (word[5:0])
                `MIPS_FN_ADDU: item.value = a + b;
                `MIPS_FN_SUBU: item.value = a - b;
                `MIPS_FN_AND:  item.value = a & b;
                `MIPS_FN_OR:   item.value = a | b;
                `MIPS_FN_XOR:  item.value = a ^ b;
                `MIPS_FN_NOR:  item.value = ~(a | b);
                `MIPS_FN_SLT:  item.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `MIPS_FN_SLTU: item.value = (a < b) ? 32'd1 : 32'd0;
                `MIPS_FN_SLL:  item.value = b << sh;
                `MIPS_FN_SRL:  item.value = b >> sh;
                `MIPS_FN_SRA:  item.value = $signed(b) >>> sh;
                default:       legal = 1'b0;
            endcase
        end else begin
            case (word[31:26])
                `MIPS_OP_ADDIU: item.value = a + immS;
                `MIPS_OP_SLTI:  item.value = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
                `MIPS_OP_SLTIU: item.value = (a < immS) ? 32'd1 : 32'd0;
                `MIPS_OP_ANDI:  item.value = a & immZ;
                `MIPS_OP_ORI:   item.value = a | immZ;
                `MIPS_OP_XORI:  item.value = a ^ immZ;
                `MIPS_OP_LUI:   item.value = {word[15:0], 16'h0000};
                default:        legal = 1'b0;
            endcase
        end
        if (legal) begin
            expQ.push_back(item);
            // Register 0 keeps reading zero
            if (item.destReg != '0) begin
                modelRegs[item.destReg] = item.value;
            end
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic issueInstr(input word_t word);
        instrValid = 1'b1;
        instr      = word;
        executeModel(word);
        @(posedge CLK);
        #1;
    endtask

    task automatic idleCycle();
        instrValid = 1'b0;
        instr      = takeBits(32);
        @(posedge CLK);
        #1;
    endtask

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkRegAddr(input regAddr_t got, input regAddr_t expected);
        if (got !== expected) begin
            $display("ERR %0t: retire register %0d, expected %0d", $time, got, expected);
            abortRun();
        end
    endtask

    task automatic checkWord(input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("ERR %0t: retire data %h, expected %h", $time, got, expected);
            abortRun();
        end
    endtask

    task automatic checkCycle(input int got, input int expected);
        if (got != expected) begin
            $display("ERR %0t: retire in cycle %0d, expected cycle %0d", $time, got, expected);
            abortRun();
        end
    endtask

    // Outputs are sampled at the falling edge, half a cycle after they change
    always @(negedge CLK) begin
        if (retireValid === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("Retire of register %0d at %0t with no instruction outstanding",
                         retireReg, $time);
                abortRun();
            end else begin
                popped = expQ.pop_front();
                checkCycle(cycleCount, popped.cycle);
                checkRegAddr(retireReg, popped.destReg);
                checkWord(retireData, popped.value);
            end
        end else if (retireValid !== 1'b0) begin
            $display("retireValid is unknown at %0t", $time);
            abortRun();
        end else if (expQ.size() != 0 && cycleCount >= expQ[0].cycle) begin
            $display("Expected retire of register %0d missing at %0t", expQ[0].destReg, $time);
            abortRun();
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        repeat (ResetCycles) @(posedge CLK);
        #1;
        rstN = 1'b1;

        // Nothing may retire while instrValid is low
        repeat (IdleCycles) idleCycle();

        for (int i = 0; i < NumRType; i++) begin
            issueInstr(randomR(randomReg(), randomReg(), randomReg()));
        end

        // Every second immediate has its top bit forced
        for (int i = 0; i < NumIType; i++) begin
            issueInstr(randomI(randomReg(), randomReg(), i[0]));
        end

        for (int i = 0; i < NumChain; i++) begin
            if (takeBits(1) != '0) begin
                issueInstr(randomR(chainReg(), chainReg(), chainReg()));
            end else begin
                issueInstr(randomI(chainReg(), chainReg(), 1'b0));
            end
        end

        // Illegal words, register 0 writes and reads, with gaps
        for (int i = 0; i < NumMixed; i++) begin
            if (takeBits(1) != '0) begin
                idleCycle();
            end
            case (takeBits(2))
                32'd0:   issueInstr(randomIllegal());
                32'd1:   issueInstr(randomR(chainReg(), chainReg(), '0));
                32'd2:   issueInstr(randomI('0, chainReg(), 1'b1));
                default: issueInstr(randomI(chainReg(), '0, 1'b0));
            endcase
        end

        while (expQ.size() != 0) begin
            idleCycle();
        end
        // Catch a stray retire after the last one
        repeat (5) idleCycle();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
